/* common/ICachePkg.sv */
`default_nettype none

package ICachePkg;

    // *************************************************************************
    // cache geometry shared by the fetch side
    // *************************************************************************

    localparam int CLSIZE_E = 5;  // 32 byte lines, eight words
    localparam int FETCH_W = 128;  // half of a line

    // *************************************************************************
    // memory controller commands
    // *************************************************************************

    typedef enum logic [1:0] {
        MEMC_NONE = 2'd0,
        MEMC_CP_EXT_TO_CACHE = 2'd1  // line fill from external memory
    } MemcCmd;

endpackage

`default_nettype wire

/* hdl/ICacheTop.sv */
`timescale 1ns/1ns
`default_nettype none

module ICacheTop #(
    parameter ASSOC = 2,
    parameter CACHE_SIZE_E = 10
) (
    input wire clk,
    input wire rst,

    input wire lookupValid,
    input wire [31:0] lookupPC,
    output logic stall,
    output logic [ICachePkg::FETCH_W-1:0] fetchData,

    output logic extReadEn,
    output logic [31:0] extAddr,
    input wire [31:0] extData
);
    import ICachePkg::*;

    localparam NUM_ICACHE_LINES = (1 << (CACHE_SIZE_E - CLSIZE_E));
    localparam WA_W = CACHE_SIZE_E - 2;
    localparam BA_W = CACHE_SIZE_E - 4;

    logic [BA_W-1:0] lookupAddress;

    MemcCmd memcCmd;
    logic [WA_W-1:0] memcCacheAddr;
    logic [31:0] memcReadAddr;
    logic memcBusy;

    logic xferValid;
    logic [31:0] xferReadAddr;
    logic [WA_W-1:0] xferCacheAddr;

    logic wrEn;
    logic [WA_W-1:0] wrAddr;
    logic [31:0] wrData;

    ICacheTable #(
        .ASSOC(ASSOC),
        .CACHE_SIZE_E(CACHE_SIZE_E),
        .NUM_ICACHE_LINES(NUM_ICACHE_LINES)
    ) tagTable (
        .clk(clk),
        .rst(rst),
        .lookupValid(lookupValid),
        .lookupPC(lookupPC),
        .lookupAddress(lookupAddress),
        .stall(stall),
        .memcCmd(memcCmd),
        .memcCacheAddr(memcCacheAddr),
        .memcReadAddr(memcReadAddr),
        .memcBusy(memcBusy),
        .xferValid(xferValid),
        .xferReadAddr(xferReadAddr),
        .xferCacheAddr(xferCacheAddr)
    );

    ICacheData #(
        .CACHE_SIZE_E(CACHE_SIZE_E)
    ) dataArray (
        .clk(clk),
        .rdAddr(lookupAddress),
        .rdData(fetchData),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData)
    );

    MemController #(
        .CACHE_SIZE_E(CACHE_SIZE_E)
    ) memCtrl (
        .clk(clk),
        .rst(rst),
        .memcCmd(memcCmd),
        .memcCacheAddr(memcCacheAddr),
        .memcReadAddr(memcReadAddr),
        .memcBusy(memcBusy),
        .xferValid(xferValid),
        .xferReadAddr(xferReadAddr),
        .xferCacheAddr(xferCacheAddr),
        .extReadEn(extReadEn),
        .extAddr(extAddr),
        .extData(extData),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData)
    );

endmodule

`default_nettype wire

/* hdl/MemController.sv */
`timescale 1ns/1ns
`default_nettype none

module MemController #(
    parameter CACHE_SIZE_E = 10
) (
    input wire clk,
    input wire rst,

    input wire ICachePkg::MemcCmd memcCmd,
    input wire [CACHE_SIZE_E-3:0] memcCacheAddr,
    input wire [31:0] memcReadAddr,
    output logic memcBusy,

    output logic xferValid,
    output logic [31:0] xferReadAddr,
    output logic [CACHE_SIZE_E-3:0] xferCacheAddr,

    output logic extReadEn,
    output logic [31:0] extAddr,
    input wire [31:0] extData,

    output logic wrEn,
    output logic [CACHE_SIZE_E-3:0] wrAddr,
    output logic [31:0] wrData
);
    import ICachePkg::*;

    localparam WA_W = CACHE_SIZE_E - 2;
    localparam WSEL_W = CLSIZE_E - 2;

    logic active;
    logic issuing;  // strobes still to send
    logic [WSEL_W-1:0] issueCnt;
    logic [WSEL_W-1:0] retCnt;
    logic dataPend;  // extData valid this cycle

    assign memcBusy = active;
    assign xferValid = active;

    // *************************************************************************
    // single slot line fill
    // *************************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            issuing <= 1'b0;
            issueCnt <= '0;
            retCnt <= '0;
            extReadEn <= 1'b0;
            dataPend <= 1'b0;
            wrEn <= 1'b0;
        end else begin
            dataPend <= extReadEn;
            wrEn <= dataPend;
            extReadEn <= 1'b0;

            if (!active && memcCmd == MEMC_CP_EXT_TO_CACHE) begin
                active <= 1'b1;
                issuing <= 1'b1;
                xferReadAddr <= memcReadAddr;
                xferCacheAddr <= memcCacheAddr;
                extReadEn <= 1'b1;  // first word right away
                extAddr <= memcReadAddr;
                issueCnt <= WSEL_W'(1);
                retCnt <= '0;
            end else if (issuing) begin
                extReadEn <= 1'b1;
                extAddr <= {xferReadAddr[31:CLSIZE_E], issueCnt, 2'b00};
                issueCnt <= issueCnt + WSEL_W'(1);
                if (&issueCnt) begin
                    issuing <= 1'b0;
                end
            end

            if (dataPend) begin
                wrData <= extData;
                wrAddr <= {xferCacheAddr[WA_W-1:WSEL_W], retCnt};
                retCnt <= retCnt + WSEL_W'(1);
            end

            if (wrEn && &wrAddr[WSEL_W-1:0]) begin
                active <= 1'b0;  // last word of the line written
            end
        end
    end

    wrOnlyInXfer: assert property (@(posedge clk) disable iff (rst)
        wrEn |-> active);

    drainedOnRelease: assert property (@(posedge clk) disable iff (rst)
        $fell(active) |-> !issuing && !dataPend && retCnt == '0);

endmodule

`default_nettype wire

/* icache/ICacheData.sv */
`timescale 1ns/1ns
`default_nettype none

module ICacheData #(
    parameter CACHE_SIZE_E = 10
) (
    input wire clk,

    input wire [CACHE_SIZE_E-5:0] rdAddr,
    output logic [ICachePkg::FETCH_W-1:0] rdData,

    input wire wrEn,
    input wire [CACHE_SIZE_E-3:0] wrAddr,
    input wire [31:0] wrData
);
    import ICachePkg::*;

    localparam WA_W = CACHE_SIZE_E - 2;
    localparam BLK_WORDS = FETCH_W / 32;
    localparam BSEL_W = $clog2(BLK_WORDS);
    localparam BANK_DEPTH = (1 << WA_W) / BLK_WORDS;

    // *************************************************************************
    // one word bank per position in the fetch block
    // *************************************************************************

    genvar b;
    generate
        for (b = 0; b < BLK_WORDS; b++) begin : gBank
            logic [31:0] bank [BANK_DEPTH];
            logic bankWr;

            assign bankWr = wrEn && wrAddr[BSEL_W-1:0] == BSEL_W'(b);

            always_ff @(posedge clk) begin
                if (bankWr) begin
                    bank[wrAddr[WA_W-1:BSEL_W]] <= wrData;
                end
            end

            always_ff @(posedge clk) begin
                rdData[b*32 +: 32] <= bank[rdAddr];  // old word on same-cycle write
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* icache/ICacheTable.sv */
`timescale 1ns/1ns
`default_nettype none

module ICacheTable #(
    parameter ASSOC = 2,
    parameter CACHE_SIZE_E = 10,
    parameter NUM_ICACHE_LINES = (1 << (CACHE_SIZE_E - ICachePkg::CLSIZE_E))
) (
    input wire clk,
    input wire rst,

    input wire lookupValid,
    input wire [31:0] lookupPC,
    output logic [CACHE_SIZE_E-5:0] lookupAddress,
    output logic stall,

    output ICachePkg::MemcCmd memcCmd,
    output logic [CACHE_SIZE_E-3:0] memcCacheAddr,
    output logic [31:0] memcReadAddr,
    input wire memcBusy,

    input wire xferValid,
    input wire [31:0] xferReadAddr,
    input wire [CACHE_SIZE_E-3:0] xferCacheAddr
);
    import ICachePkg::*;

    localparam LEN = NUM_ICACHE_LINES / ASSOC;
    localparam IDX_W = $clog2(LEN);
    localparam WAY_W = $clog2(ASSOC);
    localparam TAG_W = 32 - CLSIZE_E - IDX_W;
    localparam WA_W = CACHE_SIZE_E - 2;
    localparam WSEL_W = CLSIZE_E - 2;
    localparam IDLE = 1'b0;
    localparam CLEAN = 1'b1;

    logic [TAG_W-1:0] tags [LEN][ASSOC];
    logic [ASSOC-1:0] valid [LEN];
    logic [WAY_W-1:0] counters [LEN];  // next victim per set

    logic state;
    logic [IDX_W-1:0] cleanIdx;

    logic [IDX_W-1:0] setIdx;
    logic [TAG_W-1:0] pcTag;
    logic [WAY_W-1:0] victim;
    logic [WA_W-1:0] newLineAddr;
    logic tagHit;
    logic [WAY_W-1:0] hitWay;
    logic blocked;
    logic entryFound;
    logic doLoad;

    // *************************************************************************
    // lookup and collision check
    // *************************************************************************

    always_comb begin
        setIdx = lookupPC[CLSIZE_E +: IDX_W];
        pcTag = lookupPC[31 -: TAG_W];
        victim = counters[setIdx];
        newLineAddr = {victim, setIdx, {WSEL_W{1'b0}}};

        tagHit = 1'b0;
        hitWay = '0;
        for (int i = 0; i < ASSOC; i++) begin
            if (valid[setIdx][i] && tags[setIdx][i] == pcTag) begin
                tagHit = 1'b1;
                hitWay = WAY_W'(i);
            end
        end

        blocked = 1'b0;
        if (xferValid &&
            (lookupPC[31:CLSIZE_E] == xferReadAddr[31:CLSIZE_E] ||
             newLineAddr[WA_W-1:WSEL_W] == xferCacheAddr[WA_W-1:WSEL_W])) begin
            blocked = 1'b1;  // line or slot being filled
        end
        if (memcCmd != MEMC_NONE &&
            lookupPC[31:CLSIZE_E] == memcReadAddr[31:CLSIZE_E]) begin
            blocked = 1'b1;  // fill requested, not yet accepted
        end

        entryFound = tagHit && !blocked;
        doLoad = lookupValid && !tagHit && !blocked;
    end

    assign lookupAddress = {hitWay, setIdx, lookupPC[CLSIZE_E-1:4]};
    assign stall = lookupValid && (!entryFound || state == CLEAN);

    // *************************************************************************
    // table update, fill request and clean sweep
    // *************************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CLEAN;
            cleanIdx <= '0;
            memcCmd <= MEMC_NONE;
        end else begin
            if (!(memcCmd != MEMC_NONE && memcBusy)) begin
                memcCmd <= MEMC_NONE;
            end

            case (state)
                CLEAN: begin
                    valid[cleanIdx] <= '0;
                    counters[cleanIdx] <= '0;
                    if (cleanIdx == IDX_W'(LEN - 1)) begin
                        state <= IDLE;
                    end
                    cleanIdx <= cleanIdx + IDX_W'(1);
                end
                default: begin
                    if (lookupValid && entryFound && hitWay == victim) begin
                        counters[setIdx] <= victim + WAY_W'(1);  // wraps
                    end
                    if (doLoad && memcCmd == MEMC_NONE && !memcBusy) begin
                        memcCmd <= MEMC_CP_EXT_TO_CACHE;
                        memcCacheAddr <= newLineAddr;
                        memcReadAddr <= {lookupPC[31:CLSIZE_E], {CLSIZE_E{1'b0}}};
                        tags[setIdx][victim] <= pcTag;
                        valid[setIdx][victim] <= 1'b1;  // blocked until fill ends
                    end
                end
            endcase
        end
    end

    noCmdWhileBusy: assert property (@(posedge clk) disable iff (rst)
        memcCmd != MEMC_NONE |-> !memcBusy);

    releaseAfterSweep: assert property (@(posedge clk) disable iff (rst)
        lookupValid && !stall |-> state == IDLE && cleanIdx == '0);

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module ICacheTb \
    --Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* src.f */
common/ICachePkg.sv
icache/ICacheTable.sv
icache/ICacheData.sv
hdl/MemController.sv
hdl/ICacheTop.sv
tests/ExtMemModel.sv
tests/ICacheTb.sv

/* tests/ExtMemModel.sv */
`timescale 1ns/1ns
`default_nettype none

module ExtMemModel (
    input wire clk,
    input wire readEn,
    input wire [31:0] addr,
    output logic [31:0] rdData
);
    localparam logic [31:0] PATTERN = 32'hA5A5_0000;  // folded into every address

    initial begin
        rdData = '0;
    end

    always @(posedge clk) begin
        if (readEn) begin
            rdData <= addr ^ PATTERN;  // one cycle read latency
        end
    end

endmodule

`default_nettype wire

/* tests/ICacheTb.sv */
`timescale 1ns/1ns
`default_nettype none

module ICacheTb;
    localparam CACHE_SIZE_E = 10;
    localparam ASSOC = 2;
    localparam SETS = (1 << (CACHE_SIZE_E - 5)) / ASSOC;  // 32 byte lines
    localparam IDX_W = $clog2(SETS);
    localparam DRIVE_DLY = 1;
    localparam WAIT_LIMIT = 200;
    localparam SEED = 10821;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic lookupValid = 1'b0;
    logic [31:0] lookupPC = '0;
    logic stall;
    logic [127:0] fetchData;
    logic extReadEn;
    logic [31:0] extAddr;
    logic [31:0] extData;

    int errors = 0;
    int errMark = 0;
    int testCount = 0;
    int failedTests = 0;
    logic [31:0] strobeAddrs [$];

    logic [26:0] modelLine [SETS][ASSOC];  // line address per set and way
    logic modelValid [SETS][ASSOC];
    int modelCnt [SETS];

    ICacheTop #(
        .ASSOC(ASSOC),
        .CACHE_SIZE_E(CACHE_SIZE_E)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .lookupValid(lookupValid),
        .lookupPC(lookupPC),
        .stall(stall),
        .fetchData(fetchData),
        .extReadEn(extReadEn),
        .extAddr(extAddr),
        .extData(extData)
    );

    ExtMemModel memModel (
        .clk(clk),
        .readEn(extReadEn),
        .addr(extAddr),
        .rdData(extData)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (extReadEn) begin
            strobeAddrs.push_back(extAddr);
        end
    end

    // *************************************************************************
    // reference model of tags, victim counters and memory content
    // *************************************************************************

    function automatic int setOf(input logic [31:0] pc);
        return int'(pc[5 +: IDX_W]);
    endfunction

    function automatic int findWay(input logic [31:0] pc);
        int way;
        way = -1;
        for (int w = 0; w < ASSOC; w++) begin
            if (modelValid[setOf(pc)][w] && modelLine[setOf(pc)][w] == pc[31:5]) begin
                way = w;
            end
        end
        return way;
    endfunction

    function automatic void fillModel(input logic [31:0] pc);
        modelLine[setOf(pc)][modelCnt[setOf(pc)]] = pc[31:5];
        modelValid[setOf(pc)][modelCnt[setOf(pc)]] = 1'b1;
    endfunction

    function automatic void advanceOnHit(input logic [31:0] pc);
        if (findWay(pc) == modelCnt[setOf(pc)]) begin
            modelCnt[setOf(pc)] = (modelCnt[setOf(pc)] + 1) % ASSOC;
        end
    endfunction

    function automatic logic [127:0] modelBlock(input logic [31:0] pc);
        logic [127:0] blk;
        logic [31:0] addr;
        for (int i = 0; i < 4; i++) begin
            addr = {pc[31:4], 4'b0000} + 32'(4 * i);
            blk[i*32 +: 32] = addr ^ 32'hA5A5_0000;
        end
        return blk;
    endfunction

    // *************************************************************************
    // drive and check helpers
    // *************************************************************************

    task automatic nextDrive();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic verifyData(input logic [31:0] pc);
        if (fetchData !== modelBlock(pc)) begin
            $display("FAILED fetchData at pc %h: expected %h, got %h",
                pc, modelBlock(pc), fetchData);
            errors++;
        end
    endtask

    task automatic waitStallLow(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (stall && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (stall) begin
            $display("timeout while stall stayed high for pc %h", lookupPC);
            errors++;
        end
    endtask

    task automatic compareStrobes(input logic [31:0] pc, input int first);
        logic [31:0] want;
        for (int i = 0; i < 8; i++) begin
            want = {pc[31:5], 5'b00000} + 32'(4 * i);
            if (first + i >= strobeAddrs.size()) begin
                $display("read strobe for address %h never appeared", want);
                errors++;
            end else if (strobeAddrs[first + i] !== want) begin
                $display("FAILED extAddr: expected %h, got %h", want, strobeAddrs[first + i]);
                errors++;
            end
        end
    endtask

    task automatic fetchBlock(input logic [31:0] pc, input int extraHits,
                              output int cycles, output int strobes);
        bit miss;
        miss = findWay(pc) < 0;
        nextDrive();
        strobeAddrs.delete();
        lookupValid = 1'b1;
        lookupPC = pc;
        waitStallLow(cycles);
        if (miss) begin
            fillModel(pc);
        end
        for (int k = 0; k <= extraHits; k++) begin
            if (k > 0 && stall) begin
                $display("FAILED stall on held hit at pc %h: expected 0, got %h", pc, stall);
                errors++;
            end
            advanceOnHit(pc);
            nextDrive();
            lookupValid = (k < extraHits);
            @(negedge clk);
            verifyData(pc);
        end
        strobes = strobeAddrs.size();
        if (strobes != (miss ? 8 : 0)) begin
            $display("FAILED extReadEn count at pc %h: expected %h, got %h",
                pc, miss ? 8 : 0, strobes);
            errors++;
        end else if (miss) begin
            compareStrobes(pc, 0);
        end
        if (!miss && cycles != 0) begin
            $display("hit at pc %h stalled for %0d cycles", pc, cycles);
            errors++;
        end
    endtask

    task automatic reportTest(input string name);
        testCount++;
        if (errors == errMark) begin
            $display("%s: passed", name);
        end else begin
            failedTests++;
            $display("%s: failed with %0d errors", name, errors - errMark);
        end
        errMark = errors;
    endtask

    // *************************************************************************
    // directed tests
    // *************************************************************************

    task automatic resetSweepColdMiss();
        int cycles;
        int strobes;
        fetchBlock(32'h0000_1004, 0, cycles, strobes);
        if (cycles < SETS) begin
            $display("stall fell after %0d cycles, before the clean sweep ended", cycles);
            errors++;
        end
        reportTest("reset sweep and cold miss");
    endtask

    task automatic hitNoTraffic();
        int cycles;
        int strobes;
        fetchBlock(32'h0000_1000, 0, cycles, strobes);
        fetchBlock(32'h0000_1014, 0, cycles, strobes);
        fetchBlock(32'h0000_1008, 0, cycles, strobes);
        fetchBlock(32'h0000_101C, 0, cycles, strobes);
        reportTest("hit with no external traffic");
    endtask

    task automatic replacementOrder();
        int cycles;
        int strobes;
        logic [31:0] lines [3];
        logic [31:0] evicted;
        logic [31:0] kept;
        lines = '{32'h0000_2060, 32'h0000_2260, 32'h0000_2460};  // all in set 3
        fetchBlock(lines[0], 0, cycles, strobes);
        fetchBlock(lines[1], 0, cycles, strobes);
        evicted = {modelLine[setOf(lines[2])][modelCnt[setOf(lines[2])]], 5'b00000};
        kept = (evicted == lines[0]) ? lines[1] : lines[0];
        fetchBlock(lines[2], 0, cycles, strobes);
        fetchBlock(kept, 0, cycles, strobes);
        if (strobes != 0) begin
            $display("FAILED extReadEn count for kept line %h: expected %h, got %h",
                kept, 0, strobes);
            errors++;
        end
        fetchBlock(evicted, 0, cycles, strobes);
        if (strobes != 8) begin
            $display("FAILED extReadEn count for evicted line: expected %h, got %h", 8, strobes);
            errors++;
        end
        reportTest("replacement order");
    endtask

    task automatic noDuplicateFill();
        int cycles;
        int strobes;
        fetchBlock(32'h0000_4088, 3, cycles, strobes);  // held through fill and beyond
        reportTest("no duplicate fill");
    endtask

    task automatic backPressure();
        logic [31:0] pcA;
        logic [31:0] pcB;
        int cycles;
        int strobes;
        pcA = 32'h0000_50A0;
        pcB = 32'h0000_60C4;
        nextDrive();
        strobeAddrs.delete();
        lookupValid = 1'b1;
        lookupPC = pcA;
        cycles = 0;
        @(negedge clk);
        while (!extReadEn && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!extReadEn) begin
            $display("timeout while waiting for the first read strobe of line %h", pcA);
            errors++;
        end
        nextDrive();
        lookupPC = pcB;
        fillModel(pcA);  // filled but never hit
        waitStallLow(cycles);
        fillModel(pcB);
        advanceOnHit(pcB);
        nextDrive();
        lookupValid = 1'b0;
        @(negedge clk);
        verifyData(pcB);
        if (strobeAddrs.size() != 16) begin
            $display("FAILED extReadEn count: expected %h, got %h", 16, strobeAddrs.size());
            errors++;
        end
        compareStrobes(pcA, 0);
        compareStrobes(pcB, 8);
        fetchBlock(pcA, 0, cycles, strobes);
        reportTest("back-pressure");
    endtask

    task automatic randomStream();
        int cycles;
        int strobes;
        int fills;
        int modelFills;
        logic [31:0] pc;
        fills = 0;
        modelFills = 0;
        for (int n = 0; n < 40; n++) begin
            pc = 32'h0000_8000 + ($urandom % 2048);  // 64 lines, four per set
            pc[1:0] = 2'b00;
            if (findWay(pc) < 0) begin
                modelFills++;
            end
            fetchBlock(pc, 0, cycles, strobes);
            fills += strobes / 8;
        end
        if (fills != modelFills) begin
            $display("FAILED line fills: expected %h, got %h", modelFills, fills);
            errors++;
        end
        reportTest("random stream");
    endtask

    initial begin
        void'($urandom(SEED));
        for (int s = 0; s < SETS; s++) begin
            modelCnt[s] = 0;
            for (int w = 0; w < ASSOC; w++) begin
                modelValid[s][w] = 1'b0;
                modelLine[s][w] = '0;
            end
        end
        repeat (8) nextDrive();
        rst = 1'b0;
        resetSweepColdMiss();
        hitNoTraffic();
        replacementOrder();
        noDuplicateFill();
        backPressure();
        randomStream();
        $display("tests %0d, failed tests %0d, failed checks %0d",
            testCount, failedTests, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
